// ==== rtl/mfu_cfg_pkg.sv ====
package mfu_cfg_pkg;

    // Vector geometry
    parameter int NUM_LANES  = 4;
    parameter int LANE_WIDTH = 16;

    // Register bank depth is 2**VRF_AWIDTH entries
    parameter int VRF_AWIDTH = 4;

    // One two's complement lane
    typedef logic signed [LANE_WIDTH-1:0] lane_t;

    // Lane 0 sits in the low bits
    typedef logic [NUM_LANES-1:0][LANE_WIDTH-1:0] vec_t;

    typedef logic [VRF_AWIDTH-1:0] vrf_addr_t;

    // Operation issued with each vector
    typedef enum logic [1:0] {
        OP_ACT    = 2'd0,
        OP_ADD    = 2'd1,
        OP_MUL    = 2'd2,
        OP_BYPASS = 2'd3
    } op_e;

    // Activation function picked by the host for OP_ACT
    typedef enum logic {
        ACT_RELU = 1'b0,
        ACT_TANH = 1'b1
    } act_e;

    // Mode seen by the activation unit, PASS covers bypass
    typedef enum logic [1:0] {
        MODE_RELU = 2'd0,
        MODE_TANH = 2'd1,
        MODE_PASS = 2'd2
    } act_mode_e;

endpackage

// ==== rtl/tanh_lut_pkg.sv ====
package tanh_lut_pkg;

    parameter int TANH_SEGMENTS = 11;

    // Lower bound of each segment, scanned from segment 0 downwards
    // Segment 10 takes everything below -89
    parameter int tanh_lo [TANH_SEGMENTS] = '{
        90, 39, 28, 16, 1,
        0,
        -15, -27, -38, -89,
        32'sh8000_0000
    };

    // Slope per segment
    parameter int tanh_slope [TANH_SEGMENTS] = '{
        0, 0, 2, 3, 4,
        0,
        4, 3, 2, 0, 0
    };

    // Intercept per segment, odd symmetric around zero
    parameter int tanh_icpt [TANH_SEGMENTS] = '{
        127, 99, 46, 18, 0,
        0,
        0, -18, -46, -99, -127
    };

endpackage

// ==== rtl/vrf_port_if.sv ====
interface vrf_port_if #(
    parameter int NUM_LANES  = mfu_cfg_pkg::NUM_LANES,
    parameter int LANE_WIDTH = mfu_cfg_pkg::LANE_WIDTH,
    parameter int VRF_AWIDTH = mfu_cfg_pkg::VRF_AWIDTH
);

    // Write port
    logic                                 wr_en;
    logic [VRF_AWIDTH-1:0]                wr_addr;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] wr_data;

    // Read port, data one cycle after rd_en
    logic                                 rd_en;
    logic [VRF_AWIDTH-1:0]                rd_addr;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] rd_data;

    modport host (output wr_en, wr_addr, wr_data, rd_en, rd_addr, input rd_data);

    modport mem (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);

endinterface

// ==== rtl/vector_regfile.sv ====
module vector_regfile #(
    parameter int NUM_LANES  = mfu_cfg_pkg::NUM_LANES,
    parameter int LANE_WIDTH = mfu_cfg_pkg::LANE_WIDTH,
    parameter int VRF_AWIDTH = mfu_cfg_pkg::VRF_AWIDTH
) (
    input logic      clk,
    vrf_port_if.mem  bank
);

    localparam int DEPTH = 2 ** VRF_AWIDTH;

    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] mem [DEPTH];

    // Host write port
    always_ff @(posedge clk) begin
        if (bank.wr_en) begin
            mem[bank.wr_addr] <= bank.wr_data;
        end
    end

    // Registered read, returns old contents on a same-address write
    always_ff @(posedge clk) begin
        if (bank.rd_en) begin
            bank.rd_data <= mem[bank.rd_addr];
        end
    end

endmodule

// ==== rtl/elt_arith_unit.sv ====
module elt_arith_unit #(
    parameter int NUM_LANES  = mfu_cfg_pkg::NUM_LANES,
    parameter int LANE_WIDTH = mfu_cfg_pkg::LANE_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] primary_data,
    input  logic                                 is_mul,
    input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] add_operand,
    input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] mul_operand,
    output logic [NUM_LANES-1:0][LANE_WIDTH-1:0] result
);

    localparam int HALF = LANE_WIDTH / 2;

    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] prim_s1;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lane_res;
    logic                                 is_mul_s1;

    // Stage 1 lines up the primary vector with the bank read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_mul_s1 <= 1'b0;
        end else begin
            is_mul_s1 <= is_mul;
        end
    end

    always_ff @(posedge clk) begin
        prim_s1 <= primary_data;
    end

    // Wrapping sum, or unsigned half-width product at full lane width
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (is_mul_s1) begin
                lane_res[i] = LANE_WIDTH'(prim_s1[i][HALF-1:0])
                            * LANE_WIDTH'(mul_operand[i][HALF-1:0]);
            end else begin
                lane_res[i] = prim_s1[i] + add_operand[i];
            end
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        result <= lane_res;
    end

endmodule

// ==== rtl/act_unit.sv ====
module act_unit #(
    parameter int NUM_LANES  = mfu_cfg_pkg::NUM_LANES,
    parameter int LANE_WIDTH = mfu_cfg_pkg::LANE_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  mfu_cfg_pkg::act_mode_e               act_mode,
    input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] primary_data,
    output logic [NUM_LANES-1:0][LANE_WIDTH-1:0] result
);

    localparam int SEG_W = $clog2(tanh_lut_pkg::TANH_SEGMENTS);

    logic [NUM_LANES-1:0][SEG_W-1:0]      seg_d;
    logic [NUM_LANES-1:0][SEG_W-1:0]      seg_s1;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] x_s1;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] tanh_val;
    mfu_cfg_pkg::act_mode_e               mode_s1;

    // Segment lookup, the lowest index whose bound is not above x wins
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            seg_d[i] = SEG_W'(tanh_lut_pkg::TANH_SEGMENTS - 1);
            for (int s = tanh_lut_pkg::TANH_SEGMENTS - 1; s >= 0; s--) begin
                if ($signed(primary_data[i]) >= tanh_lut_pkg::tanh_lo[s]) begin
                    seg_d[i] = SEG_W'(s);
                end
            end
        end
    end

    // Stage 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_s1 <= mfu_cfg_pkg::MODE_PASS;
        end else begin
            mode_s1 <= act_mode;
        end
    end

    always_ff @(posedge clk) begin
        x_s1   <= primary_data;
        seg_s1 <= seg_d;
    end

    // Slope times x plus intercept, truncated to the lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            tanh_val[i] = LANE_WIDTH'(tanh_lut_pkg::tanh_slope[seg_s1[i]] * $signed(x_s1[i])
                                      + tanh_lut_pkg::tanh_icpt[seg_s1[i]]);
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            case (mode_s1)
                mfu_cfg_pkg::MODE_RELU: result[i] <= x_s1[i][LANE_WIDTH-1] ? '0 : x_s1[i];
                mfu_cfg_pkg::MODE_TANH: result[i] <= tanh_val[i];
                default:                result[i] <= x_s1[i];
            endcase
        end
    end

endmodule

// ==== rtl/mfu_ctrl.sv ====
module mfu_ctrl #(
    parameter int NUM_LANES  = mfu_cfg_pkg::NUM_LANES,
    parameter int LANE_WIDTH = mfu_cfg_pkg::LANE_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  mfu_cfg_pkg::op_e                     operation,
    input  mfu_cfg_pkg::act_e                    act_type,
    vrf_port_if.host                             add_port,
    vrf_port_if.host                             mul_port,
    output logic                                 is_mul,
    output mfu_cfg_pkg::act_mode_e               act_mode,
    input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] arith_result,
    input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] act_result,
    output logic                                 out_valid,
    output logic [NUM_LANES-1:0][LANE_WIDTH-1:0] out_data
);

    logic is_arith;
    logic valid_s1;
    logic valid_s2;
    logic arith_s1;
    logic arith_s2;

    assign is_arith = (operation == mfu_cfg_pkg::OP_ADD) || (operation == mfu_cfg_pkg::OP_MUL);
    assign is_mul   = (operation == mfu_cfg_pkg::OP_MUL);

    // Bank reads only for the matching operation
    assign add_port.rd_en = in_valid && (operation == mfu_cfg_pkg::OP_ADD);
    assign mul_port.rd_en = in_valid && (operation == mfu_cfg_pkg::OP_MUL);

    always_comb begin
        if (operation == mfu_cfg_pkg::OP_ACT) begin
            act_mode = (act_type == mfu_cfg_pkg::ACT_TANH) ? mfu_cfg_pkg::MODE_TANH
                                                           : mfu_cfg_pkg::MODE_RELU;
        end else begin
            act_mode = mfu_cfg_pkg::MODE_PASS;
        end
    end

    // Valid and result source travel alongside the datapath
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            arith_s1 <= 1'b0;
            arith_s2 <= 1'b0;
        end else begin
            valid_s1 <= in_valid;
            valid_s2 <= valid_s1;
            arith_s1 <= is_arith;
            arith_s2 <= arith_s1;
        end
    end

    assign out_valid = valid_s2;
    assign out_data  = arith_s2 ? arith_result : act_result;

endmodule

// ==== rtl/mfu_top.sv ====
module mfu_top #(
    parameter int NUM_LANES  = mfu_cfg_pkg::NUM_LANES,
    parameter int LANE_WIDTH = mfu_cfg_pkg::LANE_WIDTH,
    parameter int VRF_AWIDTH = mfu_cfg_pkg::VRF_AWIDTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  mfu_cfg_pkg::op_e        operation,
    input  mfu_cfg_pkg::act_e       act_type,
    input  mfu_cfg_pkg::vec_t       primary_data,
    input  mfu_cfg_pkg::vec_t       secondary_data,
    input  logic                    add_wr_en,
    input  logic                    mul_wr_en,
    input  mfu_cfg_pkg::vrf_addr_t  add_wr_addr,
    input  mfu_cfg_pkg::vrf_addr_t  add_rd_addr,
    input  mfu_cfg_pkg::vrf_addr_t  mul_wr_addr,
    input  mfu_cfg_pkg::vrf_addr_t  mul_rd_addr,
    output logic                    out_valid,
    output mfu_cfg_pkg::vec_t       out_data
);

    logic                                 is_mul;
    mfu_cfg_pkg::act_mode_e               act_mode;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] arith_result;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] act_result;

    vrf_port_if #(
        .NUM_LANES (NUM_LANES),
        .LANE_WIDTH(LANE_WIDTH),
        .VRF_AWIDTH(VRF_AWIDTH)
    ) add_port ();

    vrf_port_if #(
        .NUM_LANES (NUM_LANES),
        .LANE_WIDTH(LANE_WIDTH),
        .VRF_AWIDTH(VRF_AWIDTH)
    ) mul_port ();

    // Host side of both banks, secondary input feeds both
    assign add_port.wr_en   = add_wr_en;
    assign add_port.wr_addr = add_wr_addr;
    assign add_port.wr_data = secondary_data;
    assign add_port.rd_addr = add_rd_addr;
    assign mul_port.wr_en   = mul_wr_en;
    assign mul_port.wr_addr = mul_wr_addr;
    assign mul_port.wr_data = secondary_data;
    assign mul_port.rd_addr = mul_rd_addr;

    mfu_ctrl #(.NUM_LANES(NUM_LANES), .LANE_WIDTH(LANE_WIDTH)) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .operation   (operation),
        .act_type    (act_type),
        .add_port    (add_port.host),
        .mul_port    (mul_port.host),
        .is_mul      (is_mul),
        .act_mode    (act_mode),
        .arith_result(arith_result),
        .act_result  (act_result),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    vector_regfile #(
        .NUM_LANES (NUM_LANES),
        .LANE_WIDTH(LANE_WIDTH),
        .VRF_AWIDTH(VRF_AWIDTH)
    ) add_bank (
        .clk (clk),
        .bank(add_port.mem)
    );

    vector_regfile #(
        .NUM_LANES (NUM_LANES),
        .LANE_WIDTH(LANE_WIDTH),
        .VRF_AWIDTH(VRF_AWIDTH)
    ) mul_bank (
        .clk (clk),
        .bank(mul_port.mem)
    );

    elt_arith_unit #(.NUM_LANES(NUM_LANES), .LANE_WIDTH(LANE_WIDTH)) u_arith (
        .clk         (clk),
        .rst_n       (rst_n),
        .primary_data(primary_data),
        .is_mul      (is_mul),
        .add_operand (add_port.rd_data),
        .mul_operand (mul_port.rd_data),
        .result      (arith_result)
    );

    act_unit #(.NUM_LANES(NUM_LANES), .LANE_WIDTH(LANE_WIDTH)) u_act (
        .clk         (clk),
        .rst_n       (rst_n),
        .act_mode    (act_mode),
        .primary_data(primary_data),
        .result      (act_result)
    );

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // Free running, 4 ns period with the default half period
    always begin
        #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== sim/mfu_checker.sv ====
module mfu_checker (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic add_rd_en,
    input logic mul_rd_en,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Fixed two-cycle latency for every issue
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid by two cycles");
        end

    // Only one bank is read per issue
    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        !(add_rd_en && mul_rd_en))
        else begin
            fail_count++;
            $error("Both bank read enables high in one cycle");
        end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

endmodule

bind mfu_ctrl mfu_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .add_rd_en(add_port.rd_en),
    .mul_rd_en(mul_port.rd_en),
    .out_valid(out_valid)
);

// ==== sim/mfu_tb.sv ====
module mfu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NL          = mfu_cfg_pkg::NUM_LANES;
    localparam int LW          = mfu_cfg_pkg::LANE_WIDTH;
    localparam int AW          = mfu_cfg_pkg::VRF_AWIDTH;
    localparam int LOW_MOD     = 2 ** (LW / 2);
    localparam int DRAIN_LIMIT = 16;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid       = 1'b0;
    mfu_cfg_pkg::op_e       operation      = mfu_cfg_pkg::OP_ACT;
    mfu_cfg_pkg::act_e      act_type       = mfu_cfg_pkg::ACT_RELU;
    mfu_cfg_pkg::vec_t      primary_data   = '0;
    mfu_cfg_pkg::vec_t      secondary_data = '0;
    logic                   add_wr_en      = 1'b0;
    logic                   mul_wr_en      = 1'b0;
    mfu_cfg_pkg::vrf_addr_t add_wr_addr    = '0;
    mfu_cfg_pkg::vrf_addr_t add_rd_addr    = '0;
    mfu_cfg_pkg::vrf_addr_t mul_wr_addr    = '0;
    mfu_cfg_pkg::vrf_addr_t mul_rd_addr    = '0;
    logic                   out_valid;
    mfu_cfg_pkg::vec_t      out_data;

    integer            seed;
    int                errors   = 0;
    int                checks   = 0;
    int                tests    = 0;
    int                err_mark = 0;
    logic [1:0]        vpipe    = '0;
    mfu_cfg_pkg::vec_t exp_q [$];
    mfu_cfg_pkg::vec_t add_mem [2**AW];
    mfu_cfg_pkg::vec_t mul_mem [2**AW];
    mfu_cfg_pkg::vec_t vec;

    // Tanh inputs on and around every segment boundary
    int bounds [24] = '{90, 89, 39, 38, 28, 27, 16, 15, 1, 0, -1, -15,
                        -16, -27, -28, -38, -39, -89, -90, 200, -200, 32767, -32768, 5};

    clk_gen #(.HALF_PERIOD(2)) u_clk (.clk(clk));

    mfu_top #(.NUM_LANES(NL), .LANE_WIDTH(LW), .VRF_AWIDTH(AW)) UUT (.*);

    // Span 0 gives full-range lanes, otherwise lanes within +-span
    function automatic mfu_cfg_pkg::vec_t rand_vec(input int span);
        mfu_cfg_pkg::vec_t v;
        for (int i = 0; i < NL; i++) begin
            v[i] = (span > 0) ? LW'($random(seed) % span) : LW'($random(seed));
        end
        return v;
    endfunction

    function automatic mfu_cfg_pkg::lane_t tanh_ref(input mfu_cfg_pkg::lane_t x);
        // Lower bound, slope and intercept of the eleven segments
        int lo [11] = '{90, 39, 28, 16, 1, 0, -15, -27, -38, -89, -32768};
        int sl [11] = '{0, 0, 2, 3, 4, 0, 4, 3, 2, 0, 0};
        int ic [11] = '{127, 99, 46, 18, 0, 0, 0, -18, -46, -99, -127};
        int s;
        s = 0;
        while (int'(x) < lo[s]) begin
            s++;
        end
        return LW'(sl[s] * int'(x) + ic[s]);
    endfunction

    function automatic mfu_cfg_pkg::vec_t expect_vec(
        input mfu_cfg_pkg::op_e  op,
        input mfu_cfg_pkg::act_e act,
        input mfu_cfg_pkg::vec_t prim,
        input mfu_cfg_pkg::vec_t a,
        input mfu_cfg_pkg::vec_t m
    );
        mfu_cfg_pkg::vec_t  e;
        mfu_cfg_pkg::lane_t x;
        for (int i = 0; i < NL; i++) begin
            x = prim[i];
            case (op)
                mfu_cfg_pkg::OP_ADD:    e[i] = x + a[i];
                mfu_cfg_pkg::OP_MUL:    e[i] = LW'((int'(prim[i]) % LOW_MOD) * (int'(m[i]) % LOW_MOD));
                mfu_cfg_pkg::OP_BYPASS: e[i] = prim[i];
                default: begin
                    if (act == mfu_cfg_pkg::ACT_TANH) begin
                        e[i] = tanh_ref(x);
                    end else begin
                        e[i] = (x < 0) ? '0 : x;
                    end
                end
            endcase
        end
        return e;
    endfunction

    task automatic check_vec(input string name, input mfu_cfg_pkg::vec_t got,
                             input mfu_cfg_pkg::vec_t exp);
        checks++;
        for (int i = 0; i < NL; i++) begin
            if (got[i] !== exp[i]) begin
                errors++;
                $display("FAILED %s lane %0d: got %h expected %h", name, i, got[i], exp[i]);
            end
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic check_outputs();
        check_valid("out_valid", out_valid, vpipe[1]);
        if (out_valid === 1'b1 && exp_q.size() > 0) begin
            check_vec("out_data", out_data, exp_q.pop_front());
        end else if (out_valid === 1'b1) begin
            errors++;
            $display("Extra out_valid with no result pending");
        end else if (vpipe[1]) begin
            $display("Result missing two cycles after its issue");
        end
    endtask

    task automatic drive_cycle(
        input logic                   v,
        input mfu_cfg_pkg::op_e       op,
        input mfu_cfg_pkg::act_e      act,
        input mfu_cfg_pkg::vec_t      prim,
        input logic                   awe,
        input logic                   mwe,
        input mfu_cfg_pkg::vrf_addr_t wa
    );
        @(negedge clk);
        check_outputs();
        in_valid       = v;
        operation      = op;
        act_type       = act;
        primary_data   = prim;
        secondary_data = rand_vec(0);
        add_wr_en      = awe;
        mul_wr_en      = mwe;
        add_wr_addr    = wa;
        mul_wr_addr    = wa;
        // A quarter of the reads hit the address being written
        add_rd_addr    = (($random(seed) & 3) == 0) ? wa : AW'($random(seed));
        mul_rd_addr    = (($random(seed) & 3) == 0) ? wa : AW'($random(seed));
        vpipe          = {vpipe[0], v};
        // Banks are read before this edge's write lands
        if (v) begin
            exp_q.push_back(expect_vec(op, act, prim, add_mem[add_rd_addr], mul_mem[mul_rd_addr]));
        end
        if (awe) begin
            add_mem[wa] = secondary_data;
        end
        if (mwe) begin
            mul_mem[wa] = secondary_data;
        end
    endtask

    task automatic write_cycle(input logic awe, input logic mwe, input mfu_cfg_pkg::vrf_addr_t wa);
        drive_cycle(1'b0, mfu_cfg_pkg::OP_ACT, mfu_cfg_pkg::ACT_RELU, '0, awe, mwe, wa);
    endtask

    task automatic issue(input mfu_cfg_pkg::op_e op, input mfu_cfg_pkg::act_e act,
                         input mfu_cfg_pkg::vec_t prim);
        drive_cycle(1'b1, op, act, prim, 1'b0, 1'b0, '0);
    endtask

    task automatic drain_results();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < DRAIN_LIMIT) begin
            write_cycle(1'b0, 1'b0, '0);
            n++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("Timed out with %0d results still outstanding", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        seed  = 32'hffbef9ec;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (16) write_cycle(1'b0, 1'b0, '0);
        report_test("reset");

        for (int a = 0; a < 2**AW; a++) begin
            write_cycle(1'b1, 1'b0, AW'(a));
        end
        repeat (20) issue(mfu_cfg_pkg::OP_ADD, mfu_cfg_pkg::ACT_RELU, rand_vec(0));
        drain_results();
        report_test("add");

        for (int a = 0; a < 2**AW; a++) begin
            write_cycle(1'b0, 1'b1, AW'(a));
        end
        repeat (20) issue(mfu_cfg_pkg::OP_MUL, mfu_cfg_pkg::ACT_RELU, rand_vec(0));
        drain_results();
        report_test("mul");

        repeat (16) issue(mfu_cfg_pkg::OP_ACT, mfu_cfg_pkg::ACT_RELU, rand_vec(0));
        for (int k = 0; k < 24; k += NL) begin
            for (int i = 0; i < NL; i++) begin
                vec[i] = LW'(bounds[(k + i) % 24]);
            end
            issue(mfu_cfg_pkg::OP_ACT, mfu_cfg_pkg::ACT_TANH, vec);
        end
        repeat (16) issue(mfu_cfg_pkg::OP_ACT, mfu_cfg_pkg::ACT_TANH, rand_vec(128));
        repeat (8) issue(mfu_cfg_pkg::OP_ACT, mfu_cfg_pkg::ACT_TANH, rand_vec(0));
        drain_results();
        report_test("act");

        repeat (12) issue(mfu_cfg_pkg::OP_BYPASS, mfu_cfg_pkg::ACT_RELU, rand_vec(0));
        drain_results();
        report_test("bypass");

        // Back to back random issues while both banks keep changing
        repeat (200) begin
            vec = rand_vec((($random(seed) & 1) != 0) ? 128 : 0);
            drive_cycle(($random(seed) & 7) != 0,
                        mfu_cfg_pkg::op_e'(2'($random(seed))),
                        mfu_cfg_pkg::act_e'(1'($random(seed))),
                        vec,
                        1'($random(seed)),
                        1'($random(seed)),
                        AW'($random(seed)));
        end
        drain_results();
        report_test("mixed");

        $display("Done: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, UUT.u_ctrl.u_checker.fail_count);
        if (errors == 0 && UUT.u_ctrl.u_checker.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/mfu_cfg_pkg.sv
rtl/tanh_lut_pkg.sv
rtl/vrf_port_if.sv
rtl/vector_regfile.sv
rtl/elt_arith_unit.sv
rtl/act_unit.sv
rtl/mfu_ctrl.sv
rtl/mfu_top.sv
sim/clk_gen.sv
sim/mfu_checker.sv
sim/mfu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mfu_tb -f build.f -o mfu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mfu_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
